/* fpu_pkg.sv */
// Shared types and helpers for the single-precision arithmetic unit
// Format fields, special constants, request and response layouts

`default_nettype none

package fpu_pkg;

    // ====================
    // Format widths
    // ====================
    localparam int WORD_W = 32;
    localparam int EXP_W  = 8;
    localparam int MANT_W = 23;

    typedef logic [WORD_W-1:0] fp_word_t;
    typedef logic [EXP_W-1:0]  fp_exp_t;
    typedef logic [MANT_W-1:0] fp_mant_t;
    typedef logic [WORD_W-1:0] int_word_t;

    // Special encodings
    localparam fp_exp_t  EXP_MAX  = 8'd255;
    localparam fp_exp_t  EXP_BIAS = 8'd127;
    // Canonical quiet NaN, positive with only the top fraction bit set
    localparam fp_word_t QNAN     = 32'h7fc0_0000;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_CVT = 2'd3
    } fp_op_e;

    // Flag order kept as inexact, invalid, div_zero, overflow, underflow
    typedef struct packed {
        logic inexact;
        logic invalid;
        logic div_zero;
        logic overflow;
        logic underflow;
    } fpu_flags_t;

    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
        logic is_denorm;
    } fp_class_t;

    typedef struct packed {
        fp_op_e    op;
        fp_word_t  a;
        fp_word_t  b;
        int_word_t a_int;
    } fpu_req_t;

    typedef struct packed {
        fp_word_t   result;
        fpu_flags_t flags;
    } fpu_resp_t;

    // Operand classification from exponent and fraction fields
    function automatic fp_class_t classify(input fp_word_t w);
        fp_class_t c;
        fp_exp_t   e;
        fp_mant_t  m;
        e           = w[MANT_W +: EXP_W];
        m           = w[MANT_W-1:0];
        c.is_zero   = (e == '0) && (m == '0);
        c.is_denorm = (e == '0) && (m != '0);
        c.is_inf    = (e == EXP_MAX) && (m == '0);
        c.is_nan    = (e == EXP_MAX) && (m != '0);
        return c;
    endfunction

endpackage

`default_nettype wire

/* fp_addsub.sv */
// Single-precision adder and subtractor, purely combinational
// Round to nearest even, flush to zero when the result gets too small

`timescale 1ns/1ps
`default_nettype none

module fp_addsub
    import fpu_pkg::*;
(
    input  fp_word_t  a,
    input  fp_word_t  b,
    input  logic      sub,
    output fpu_resp_t resp
);

    // Hidden bit, fraction, guard, round and sticky
    localparam int SIG_W = MANT_W + 4;

    fp_class_t        a_cls;
    fp_class_t        b_cls;
    logic             b_sign;
    logic             swap;
    logic             big_sign;
    logic             small_sign;
    fp_exp_t          big_exp;
    fp_exp_t          small_exp;
    fp_exp_t          exp_diff;
    logic [SIG_W-1:0] big_sig;
    logic [SIG_W-1:0] small_sig;
    logic [SIG_W-1:0] small_shift;
    logic [SIG_W-1:0] lost_mask;
    logic [SIG_W-1:0] small_al;
    logic [SIG_W:0]   sum;
    logic [4:0]       lz;
    logic [SIG_W-1:0] norm;
    logic [9:0]       exp_n;
    logic [9:0]       exp_r;
    logic             tiny;
    logic             round_up;
    logic [MANT_W+1:0] rounded;
    fp_mant_t         frac_out;

    assign a_cls  = classify(a);
    assign b_cls  = classify(b);
    assign b_sign = b[WORD_W-1] ^ sub;
    // Magnitude compare works directly on the encoded words
    assign swap   = b[WORD_W-2:0] > a[WORD_W-2:0];

    // ====================
    // Alignment
    // ====================
    always_comb begin
        if (swap) begin
            big_sign   = b_sign;
            big_exp    = b_cls.is_denorm ? fp_exp_t'(1) : b[WORD_W-2:MANT_W];
            big_sig    = {~b_cls.is_denorm, b[MANT_W-1:0], 3'b000};
            small_sign = a[WORD_W-1];
            small_exp  = a_cls.is_denorm ? fp_exp_t'(1) : a[WORD_W-2:MANT_W];
            small_sig  = {~a_cls.is_denorm, a[MANT_W-1:0], 3'b000};
        end else begin
            big_sign   = a[WORD_W-1];
            big_exp    = a_cls.is_denorm ? fp_exp_t'(1) : a[WORD_W-2:MANT_W];
            big_sig    = {~a_cls.is_denorm, a[MANT_W-1:0], 3'b000};
            small_sign = b_sign;
            small_exp  = b_cls.is_denorm ? fp_exp_t'(1) : b[WORD_W-2:MANT_W];
            small_sig  = {~b_cls.is_denorm, b[MANT_W-1:0], 3'b000};
        end
    end

    assign exp_diff    = big_exp - small_exp;
    assign small_shift = small_sig >> exp_diff;
    // Bits shifted out collapse into the sticky position
    assign lost_mask   = ~({SIG_W{1'b1}} << exp_diff);
    assign small_al    = {small_shift[SIG_W-1:1],
                          small_shift[0] | (|(small_sig & lost_mask))};

    // Big side always has the larger magnitude, so no negative result
    assign sum = (big_sign == small_sign) ? {1'b0, big_sig} + {1'b0, small_al}
                                          : {1'b0, big_sig} - {1'b0, small_al};

    // ====================
    // Normalisation
    // ====================
    always_comb begin
        lz = '0;
        // Priority search, the highest set bit wins
        for (int i = 0; i < SIG_W; i++) begin
            if (sum[i]) begin
                lz = 5'(SIG_W - 1 - i);
            end
        end
        if (sum[SIG_W]) begin
            norm  = {sum[SIG_W:2], sum[1] | sum[0]};
            exp_n = {2'b00, big_exp} + 10'd1;
        end else begin
            norm  = sum[SIG_W-1:0] << lz;
            exp_n = {2'b00, big_exp} - {5'd0, lz};
        end
    end

    // Negative or zero exponent after the shift
    assign tiny = exp_n[9] | (exp_n == '0);

    // Round half to even on guard, round and sticky
    assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
    assign rounded  = {1'b0, norm[SIG_W-1:3]} + (MANT_W+2)'(round_up);
    assign exp_r    = exp_n + 10'(rounded[MANT_W+1]);
    assign frac_out = rounded[MANT_W+1] ? rounded[MANT_W:1] : rounded[MANT_W-1:0];

    // ====================
    // Result selection
    // ====================
    always_comb begin
        resp = '0;
        if (a_cls.is_nan || b_cls.is_nan) begin
            resp.result        = QNAN;
            resp.flags.invalid = 1'b1;
        end else if (a_cls.is_inf) begin
            if (b_cls.is_inf && (a[WORD_W-1] != b_sign)) begin
                resp.result        = QNAN;
                resp.flags.invalid = 1'b1;
            end else begin
                resp.result = a;
            end
        end else if (b_cls.is_inf) begin
            resp.result = {b_sign, b[WORD_W-2:0]};
        end else if (a_cls.is_zero) begin
            resp.result = {b_sign, b[WORD_W-2:0]};
        end else if (b_cls.is_zero) begin
            resp.result = a;
        end else if (sum == '0) begin
            // Exact cancellation
            resp.result = '0;
        end else if (tiny) begin
            resp.result          = {big_sign, {(WORD_W-1){1'b0}}};
            resp.flags.underflow = 1'b1;
            resp.flags.inexact   = 1'b1;
        end else if (exp_r >= {2'b00, EXP_MAX}) begin
            resp.result         = {big_sign, EXP_MAX, {MANT_W{1'b0}}};
            resp.flags.overflow = 1'b1;
            resp.flags.inexact  = 1'b1;
        end else begin
            resp.result        = {big_sign, exp_r[EXP_W-1:0], frac_out};
            resp.flags.inexact = |norm[2:0];
        end
    end

endmodule

`default_nettype wire

/* fp_mul.sv */
// Single-precision multiplier, purely combinational
// Truncated fraction, denormal inputs count as zero

`timescale 1ns/1ps
`default_nettype none

module fp_mul
    import fpu_pkg::*;
(
    input  fp_word_t  a,
    input  fp_word_t  b,
    output fpu_resp_t resp
);

    fp_class_t                a_cls;
    fp_class_t                b_cls;
    logic                     a_zero;
    logic                     b_zero;
    logic                     sign;
    logic [MANT_W:0]          a_sig;
    logic [MANT_W:0]          b_sig;
    logic [2*(MANT_W+1)-1:0]  prod;
    logic [9:0]               exp_sum;
    logic [9:0]               exp_res;
    logic                     too_big;
    logic                     too_small;
    fp_mant_t                 frac;

    assign a_cls  = classify(a);
    assign b_cls  = classify(b);
    assign a_zero = a_cls.is_zero | a_cls.is_denorm;
    assign b_zero = b_cls.is_zero | b_cls.is_denorm;
    assign sign   = a[WORD_W-1] ^ b[WORD_W-1];

    // ====================
    // Significand product
    // ====================
    assign a_sig = {1'b1, a[MANT_W-1:0]};
    assign b_sig = {1'b1, b[MANT_W-1:0]};
    assign prod  = a_sig * b_sig;

    // Product lies in [1, 4), top bit moves the exponent up by one
    assign exp_sum = {2'b00, a[WORD_W-2:MANT_W]} + {2'b00, b[WORD_W-2:MANT_W]}
                   - {2'b00, EXP_BIAS};
    assign exp_res = exp_sum + 10'(prod[2*MANT_W+1]);
    assign frac    = prod[2*MANT_W+1] ? prod[2*MANT_W:MANT_W+1]
                                      : prod[2*MANT_W-1:MANT_W];

    // Bit 9 set means the exponent went negative
    assign too_small = exp_res[9] | (exp_res == '0);
    assign too_big   = ~exp_res[9] & (exp_res >= {2'b00, EXP_MAX});

    // ====================
    // Result selection
    // ====================
    always_comb begin
        resp = '0;
        if (a_cls.is_nan || b_cls.is_nan) begin
            resp.result        = QNAN;
            resp.flags.invalid = 1'b1;
        end else if ((a_zero && b_cls.is_inf) || (a_cls.is_inf && b_zero)) begin
            resp.result        = QNAN;
            resp.flags.invalid = 1'b1;
        end else if (a_cls.is_inf || b_cls.is_inf) begin
            resp.result = {sign, EXP_MAX, {MANT_W{1'b0}}};
        end else if (a_zero || b_zero) begin
            resp.result = {sign, {(WORD_W-1){1'b0}}};
        end else if (too_big) begin
            resp.result         = {sign, EXP_MAX, {MANT_W{1'b0}}};
            resp.flags.overflow = 1'b1;
        end else if (too_small) begin
            resp.result          = {sign, {(WORD_W-1){1'b0}}};
            resp.flags.underflow = 1'b1;
        end else begin
            resp.result = {sign, exp_res[EXP_W-1:0], frac};
        end
    end

endmodule

`default_nettype wire

/* int_to_fp.sv */
// Signed 32-bit integer to single-precision conversion
// Fraction is truncated, no flags are produced

`timescale 1ns/1ps
`default_nettype none

module int_to_fp
    import fpu_pkg::*;
(
    input  int_word_t a_int,
    output fp_word_t  result
);

    logic      sign;
    int_word_t mag;
    int_word_t mag_norm;
    logic [4:0] lz;
    fp_exp_t   exp_field;

    assign sign = a_int[WORD_W-1];
    // Most negative input maps onto 2^31 as an unsigned magnitude
    assign mag  = sign ? (~a_int + 1'b1) : a_int;

    // Leading zero count, highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < WORD_W; i++) begin
            if (mag[i]) begin
                lz = 5'(WORD_W - 1 - i);
            end
        end
    end

    // Top one lands in bit 31 and becomes the hidden bit
    assign mag_norm  = mag << lz;
    // Bias plus 31 is the exponent of a value with its top one in bit 31
    assign exp_field = EXP_BIAS + fp_exp_t'(WORD_W - 1) - {3'b000, lz};

    assign result = (a_int == '0) ? '0
                                  : {sign, exp_field, mag_norm[WORD_W-2 -: MANT_W]};

endmodule

`default_nettype wire

/* fpu_alu.sv */
// Top level of the arithmetic unit
// Selects one datapath by operation and registers the response on start

`timescale 1ns/1ps
`default_nettype none

module fpu_alu
    import fpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  fpu_req_t  req,
    output logic      done,
    output fpu_resp_t resp
);

    fpu_resp_t addsub_resp;
    fpu_resp_t mul_resp;
    fpu_resp_t sel_resp;
    fp_word_t  cvt_result;
    logic      sub;

    // Only decode of the operation outside the select
    assign sub = (req.op == OP_SUB);

    // ====================
    // Datapaths
    // ====================
    fp_addsub u_addsub (
        .a    (req.a),
        .b    (req.b),
        .sub  (sub),
        .resp (addsub_resp)
    );

    fp_mul u_mul (
        .a    (req.a),
        .b    (req.b),
        .resp (mul_resp)
    );

    int_to_fp u_cvt (
        .a_int  (req.a_int),
        .result (cvt_result)
    );

    always_comb begin
        case (req.op)
            OP_ADD, OP_SUB: sel_resp = addsub_resp;
            OP_MUL:         sel_resp = mul_resp;
            OP_CVT:         sel_resp = '{result: cvt_result, flags: '0};
            default:        sel_resp = '0;
        endcase
    end

    // ====================
    // Output register
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
            resp <= '0;
        end else begin
            // One done per accepted start, resp held in between
            done <= start;
            if (start) begin
                resp <= sel_resp;
            end
        end
    end

endmodule

`default_nettype wire

/* fpu_alu_asserts.sv */
// Protocol and result consistency properties for the arithmetic unit

`timescale 1ns/1ps
`default_nettype none

module fpu_alu_asserts
    import fpu_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      start,
    input logic      done,
    input fpu_resp_t resp
);

    // Number of property failures so far
    int fail_count = 0;

    // One done per start, exactly one cycle later
    assert property (@(posedge clk) disable iff (rst) !$past(rst) |-> done == $past(start))
        else begin
            $error("done does not follow start by one cycle");
            fail_count++;
        end

    assert property (@(posedge clk) rst |=> !done)
        else begin
            $error("done high in the cycle after reset");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) resp.flags.invalid |-> resp.result == QNAN)
        else begin
            $error("invalid flag without the canonical NaN");
            fail_count++;
        end

    // Either sign of infinity
    assert property (@(posedge clk) disable iff (rst)
                     resp.flags.overflow |->
                     resp.result[WORD_W-2:0] == {EXP_MAX, {MANT_W{1'b0}}})
        else begin
            $error("overflow flag without an infinite result");
            fail_count++;
        end

endmodule

bind fpu_alu fpu_alu_asserts u_asserts (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .done  (done),
    .resp  (resp)
);

`default_nettype wire

/* tb_fpu_alu.sv */
// Self-checking testbench for the arithmetic unit
// Directed table rows plus integer-valued random rows, each checked on done

`timescale 1ns/1ps
`default_nettype none

module tb_fpu_alu
    import fpu_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_FIXED      = 19;
    localparam int N_RAND       = 16;
    localparam int N_ROWS       = N_FIXED + N_RAND;
    localparam int TIMEOUT      = 2 * N_ROWS + N_RAND + RESET_CYCLES + 20;

    // Flag patterns as {inexact, invalid, div_zero, overflow, underflow}
    localparam logic [4:0] F_NONE    = 5'b00000;
    localparam logic [4:0] F_INV     = 5'b01000;
    localparam logic [4:0] F_OVF     = 5'b00010;
    localparam logic [4:0] F_OVF_INX = 5'b10010;
    localparam logic [4:0] F_UNF     = 5'b00001;
    localparam logic [4:0] F_INX     = 5'b10000;

    typedef struct packed {
        fp_op_e     op;
        fp_word_t   a;
        fp_word_t   b;
        int_word_t  a_int;
        fp_word_t   result;
        fpu_flags_t flags;
    } row_t;

    logic      clk;
    logic      rst;
    logic      start;
    fpu_req_t  req;
    logic      done;
    fpu_resp_t resp;

    row_t rows [N_ROWS];
    int   n_loaded;
    int   cycles = 0;

    fpu_alu dut (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .req   (req),
        .done  (done),
        .resp  (resp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation failed");
            $fatal(1, "Run stopped on timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Value check failed");
        end
    endtask

    task automatic check_condition(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("Error at %0t ns: %s", $time, what);
            $display("Simulation failed");
            $fatal(1, "Condition check failed");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Exact only for magnitudes below 2^24, which is all the random rows need
    function automatic fp_word_t float_of_int(input int value);
        logic [31:0] mag;
        int          msb;
        logic [31:0] frac;
        if (value == 0) begin
            return '0;
        end
        mag = (value < 0) ? -value : value;
        msb = 0;
        while ((mag >> (msb + 1)) != 0) begin
            msb++;
        end
        frac = (msb > 23) ? (mag >> (msb - 23)) : (mag << (23 - msb));
        return {(value < 0), 8'(127 + msb), frac[22:0]};
    endfunction

    task automatic add_row(input fp_op_e op, input fp_word_t a, input fp_word_t b,
                           input int_word_t a_int, input fp_word_t result,
                           input logic [4:0] flags);
        rows[n_loaded] = '{op, a, b, a_int, result, fpu_flags_t'(flags)};
        n_loaded++;
    endtask

    // ====================
    // Stimulus table
    // ====================
    task automatic load_fixed_rows();
        // Exact sums and products
        add_row(OP_ADD, 32'h3fc0_0000, 32'h4010_0000, '0, 32'h4070_0000, F_NONE);
        add_row(OP_SUB, 32'h40a0_0000, 32'h40a0_0000, '0, 32'h0000_0000, F_NONE);
        add_row(OP_ADD, 32'hc000_0000, 32'h3f00_0000, '0, 32'hbfc0_0000, F_NONE);
        add_row(OP_MUL, 32'h4040_0000, 32'hc000_0000, '0, 32'hc0c0_0000, F_NONE);
        // Special operands
        add_row(OP_ADD, 32'h7fa0_0000, 32'h3f80_0000, '0, QNAN, F_INV);
        add_row(OP_SUB, 32'h7f80_0000, 32'h7f80_0000, '0, QNAN, F_INV);
        add_row(OP_ADD, 32'h3f80_0000, 32'hff80_0000, '0, 32'hff80_0000, F_NONE);
        add_row(OP_MUL, 32'h0000_0000, 32'h7f80_0000, '0, QNAN, F_INV);
        add_row(OP_MUL, 32'h8000_0001, 32'h4000_0000, '0, 32'h8000_0000, F_NONE);
        // Range limits
        add_row(OP_ADD, 32'h7f7f_ffff, 32'h7f7f_ffff, '0, 32'h7f80_0000, F_OVF_INX);
        add_row(OP_MUL, 32'h7f00_0000, 32'h7f00_0000, '0, 32'h7f80_0000, F_OVF);
        add_row(OP_MUL, 32'h8080_0000, 32'h0080_0000, '0, 32'h8000_0000, F_UNF);
        // Ties on the halfway point, odd rounds up and even stays
        add_row(OP_ADD, 32'h3f80_0000, 32'h3f7f_ffff, '0, 32'h4000_0000, F_INX);
        add_row(OP_ADD, 32'h3f80_0000, 32'h3380_0000, '0, 32'h3f80_0000, F_INX);
        // Integer conversion
        add_row(OP_CVT, '0, '0, 32'h0000_0000, 32'h0000_0000, F_NONE);
        add_row(OP_CVT, '0, '0, 32'h0000_0002, 32'h4000_0000, F_NONE);
        add_row(OP_CVT, '0, '0, 32'hffff_ffff, 32'hbf80_0000, F_NONE);
        add_row(OP_CVT, '0, '0, 32'h0100_0001, 32'h4b80_0000, F_NONE);
        add_row(OP_CVT, '0, '0, 32'h8000_0000, 32'hcf00_0000, F_NONE);
    endtask

    // Small nonzero integers keep every sum and product exact
    task automatic load_random_rows();
        logic [31:0] state;
        int          x;
        int          y;
        int          value;
        fp_op_e      op;
        state = 32'h0f52_868d;
        for (int k = 0; k < N_RAND; k++) begin
            state = xorshift32(state);
            x     = (state[7:0] == 8'd0) ? 1 : int'(state[7:0]);
            y     = (state[23:16] == 8'd0) ? 1 : int'(state[23:16]);
            if (state[8]) begin
                x = -x;
            end
            if (state[24]) begin
                y = -y;
            end
            op    = k[0] ? OP_MUL : OP_ADD;
            value = (op == OP_MUL) ? x * y : x + y;
            add_row(op, float_of_int(x), float_of_int(y), '0, float_of_int(value), F_NONE);
        end
    endtask

    task automatic apply_row(input row_t row, input int index);
        @(negedge clk);
        start = 1'b1;
        req   = '{row.op, row.a, row.b, row.a_int};
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        check_value($sformatf("resp.result (row %0d)", index), resp.result, row.result);
        check_value($sformatf("resp.flags (row %0d)", index), 32'(resp.flags),
                    32'(row.flags));
    endtask

    // Back-to-back starts, then an idle stretch with the response held
    task automatic run_timing_checks();
        @(negedge clk);
        start = 1'b1;
        req   = '{OP_ADD, 32'h3fc0_0000, 32'h4010_0000, 32'h0};
        @(negedge clk);
        req = '{OP_MUL, 32'h4040_0000, 32'hc000_0000, 32'h0};
        check_value("done", done, 32'd1);
        check_value("resp.result", resp.result, 32'h4070_0000);
        @(negedge clk);
        start = 1'b0;
        check_value("done", done, 32'd1);
        check_value("resp.result", resp.result, 32'hc0c0_0000);
        repeat (3) begin
            @(negedge clk);
            check_value("done", done, 32'd0);
            check_value("resp.result", resp.result, 32'hc0c0_0000);
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        req      = '0;
        n_loaded = 0;
        load_fixed_rows();
        check_condition(n_loaded == N_FIXED, "directed table size differs from N_FIXED");
        load_random_rows();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("done", done, 32'd0);
        end
        rst = 1'b0;
        // Still idle before the first start
        repeat (2) begin
            @(negedge clk);
            check_value("done", done, 32'd0);
            check_value("resp.result", resp.result, 32'd0);
            check_value("resp.flags", 32'(resp.flags), 32'd0);
        end
        for (int i = 0; i < N_ROWS; i++) begin
            apply_row(rows[i], i);
        end
        run_timing_checks();
        if (dut.u_asserts.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Property checks failed %0d times during the run",
                     dut.u_asserts.fail_count);
            $display("Simulation failed");
            $fatal(1, "Concurrent property failures");
        end
    end

endmodule

`default_nettype wire

/* src.f */
fpu_pkg.sv
fp_addsub.sv
fp_mul.sv
int_to_fp.sv
fpu_alu.sv
fpu_alu_asserts.sv
tb_fpu_alu.sv

/* Bender.yml */
package:
  name: fpu_alu

sources:
  - fpu_pkg.sv
  - fp_addsub.sv
  - fp_mul.sv
  - int_to_fp.sv
  - fpu_alu.sv
  - target: simulation
    files:
      - fpu_alu_asserts.sv
      - tb_fpu_alu.sv
